//--- src/qla_pkg.sv
// shared bus, address-map and ADC word definitions; imported by every design module

package qla_pkg;

    // ------------------------------
    // host bus widths
    // ------------------------------
    localparam int ADDR_W = 16;             // wishbone address
    localparam int DATA_W = 32;             // wishbone data

    // ------------------------------
    // address fields
    // ------------------------------
    // addr[15:12] block, addr[7:4] channel, addr[3:0] offset
    localparam int FIELD_W  = 4;            // every field is one nibble
    localparam int BLK_LSB  = 12;
    localparam int CHAN_LSB = 4;
    localparam int OFF_LSB  = 0;

    localparam logic [FIELD_W-1:0] BLK_MAIN = 4'd0;          // channel registers

    // offsets inside a channel
    localparam logic [FIELD_W-1:0] OFF_ADC_DATA     = 4'd0;  // pot + cur readback
    localparam logic [FIELD_W-1:0] OFF_DAC_CTRL     = 4'd1;  // current command
    localparam logic [FIELD_W-1:0] OFF_BOARD_STATUS = 4'd0;  // channel 0 only

    // ------------------------------
    // sample format
    // ------------------------------
    localparam int SAMPLE_W = 16;           // adc and command codes
    // offset binary, this code means zero current
    localparam logic [SAMPLE_W-1:0] MID_SCALE = 16'h8000;

    // one adc frame per axis: pot in the upper half, current below
    typedef struct packed {
        logic [SAMPLE_W-1:0] pot;
        logic [SAMPLE_W-1:0] cur;
    } adc_fields_t;

    // shifter fills raw, readback and safety logic use the fields
    typedef union packed {
        logic [2*SAMPLE_W-1:0] raw;
        adc_fields_t           f;
    } adc_word_u;

endpackage

//--- src/wb_reg_slave.sv
// wishbone classic slave with address decode, read mux and the channel 0 board register
`timescale 1ns/10ps

module wb_reg_slave #(
    parameter int NUM_AXES = 4
) (
    input  logic                       sysclk,
    input  logic                       rst_n,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [qla_pkg::ADDR_W-1:0] wb_adr,
    input  logic [qla_pkg::DATA_W-1:0] wb_dat_i,
    output logic [qla_pkg::DATA_W-1:0] wb_dat_o,
    output logic                       wb_ack,
    output logic                       reg_wen,
    output logic [qla_pkg::ADDR_W-1:0] reg_addr,
    output logic [qla_pkg::DATA_W-1:0] reg_wdata,
    input  logic [qla_pkg::DATA_W-1:0] cmd_rdata,
    input  logic [qla_pkg::DATA_W-1:0] adc_rdata,
    input  logic [NUM_AXES-1:0]        amp_disable,
    output logic [NUM_AXES-1:0]        clear_disable,
    output logic [NUM_AXES-1:0]        amp_enable
);
    import qla_pkg::*;

    localparam int STAT_LSB = 8;            // disable status in bits 11..8

    logic               access;             // new request, not yet acked
    logic [FIELD_W-1:0] blk;
    logic [FIELD_W-1:0] chan;
    logic [FIELD_W-1:0] off;
    logic               board_sel;          // channel 0 board register
    logic               axis_sel;           // channels 1..NUM_AXES
    logic [DATA_W-1:0]  rd_mux;
    logic [NUM_AXES-1:0] amp_req;           // host enable requests

    // ------------------------------
    // decode
    // ------------------------------
    assign access = wb_cyc & wb_stb & ~wb_ack;
    assign blk    = wb_adr[BLK_LSB +: FIELD_W];
    assign chan   = wb_adr[CHAN_LSB +: FIELD_W];
    assign off    = wb_adr[OFF_LSB +: FIELD_W];

    assign board_sel = (blk == BLK_MAIN) && (chan == '0) && (off == OFF_BOARD_STATUS);
    assign axis_sel  = (blk == BLK_MAIN) && (chan != '0) && (chan <= FIELD_W'(NUM_AXES));

    // write lands at the same edge that raises ack
    assign reg_wen   = access & wb_we;
    assign reg_addr  = wb_adr;              // also the read address, so reads are single cycle
    assign reg_wdata = wb_dat_i;

    // every 1 written into the enable field clears that axis' latch
    assign clear_disable = (reg_wen && board_sel) ? wb_dat_i[NUM_AXES-1:0] : '0;

    assign amp_enable = amp_req & ~amp_disable;     // trip overrides request

    // ------------------------------
    // read mux
    // ------------------------------
    always_comb begin
        rd_mux = '0;                        // unmapped reads 0
        if (board_sel) begin
            rd_mux[NUM_AXES-1:0]        = amp_req;
            rd_mux[STAT_LSB +: NUM_AXES] = amp_disable;
        end else if (axis_sel && (off == OFF_DAC_CTRL)) begin
            rd_mux = cmd_rdata;
        end else if (axis_sel && (off == OFF_ADC_DATA)) begin
            rd_mux = adc_rdata;
        end
    end

    // ack for one cycle, board register writes
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack  <= 1'b0;
            amp_req <= '0;
        end else begin
            wb_ack <= access;
            if (reg_wen && board_sel) begin
                amp_req <= wb_dat_i[NUM_AXES-1:0];
            end
        end
    end

    // read data held alongside ack
    always_ff @(posedge sysclk) begin
        if (access) begin
            wb_dat_o <= rd_mux;
        end
    end

endmodule

//--- src/dac_cmd_bank.sv
// per-axis current command registers; bus written, read back and fed to the safety check
`timescale 1ns/10ps

module dac_cmd_bank #(
    parameter int NUM_AXES = 4
) (
    input  logic                                        sysclk,
    input  logic                                        rst_n,
    input  logic                                        reg_wen,
    input  logic [qla_pkg::ADDR_W-1:0]                  reg_addr,
    input  logic [qla_pkg::DATA_W-1:0]                  reg_wdata,
    output logic [NUM_AXES-1:0][qla_pkg::SAMPLE_W-1:0]  cur_cmd,
    output logic [qla_pkg::DATA_W-1:0]                  cmd_rdata
);
    import qla_pkg::*;

    logic [FIELD_W-1:0] chan;
    logic               cmd_wr;             // write aimed at a command offset

    assign chan   = reg_addr[CHAN_LSB +: FIELD_W];
    assign cmd_wr = reg_wen && (reg_addr[BLK_LSB +: FIELD_W] == BLK_MAIN)
                    && (reg_addr[OFF_LSB +: FIELD_W] == OFF_DAC_CTRL);

    // channel n holds axis n-1
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                cur_cmd[i] <= MID_SCALE;    // zero current
            end
        end else if (cmd_wr) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (chan == FIELD_W'(i + 1)) begin
                    cur_cmd[i] <= reg_wdata[SAMPLE_W-1:0];
                end
            end
        end
    end

    // readback, zero extended
    always_comb begin
        cmd_rdata = '0;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (chan == FIELD_W'(i + 1)) begin
                cmd_rdata = {{(DATA_W-SAMPLE_W){1'b0}}, cur_cmd[i]};
            end
        end
    end

endmodule

//--- src/adc_sampler.sv
// serial adc front end; frames conv/sclk and captures one pot+current word per axis
`timescale 1ns/10ps

module adc_sampler #(
    parameter int NUM_AXES  = 4,
    parameter int ADC_FRAME = 80            // at least 66 cycles
) (
    input  logic                                        sysclk,
    input  logic                                        rst_n,
    output logic                                        adc_conv,
    output logic                                        adc_sclk,
    input  logic [NUM_AXES-1:0]                         adc_miso,
    input  logic [qla_pkg::ADDR_W-1:0]                  reg_addr,
    output logic [qla_pkg::DATA_W-1:0]                  adc_rdata,
    output logic [NUM_AXES-1:0][qla_pkg::SAMPLE_W-1:0]  cur_fb,
    output logic                                        sample_valid
);
    import qla_pkg::*;

    localparam int CNT_W      = $clog2(ADC_FRAME);
    localparam int CONV_LEN   = 2;                      // conv high cycles
    localparam int SCLK_FIRST = CONV_LEN;               // first sclk high
    localparam int SCLK_LAST  = SCLK_FIRST + 2 * 31;    // 32nd sclk high

    logic [CNT_W-1:0] cnt;                  // phase of the cycle being shown
    logic [CNT_W-1:0] cnt_nxt;
    adc_word_u        shreg [NUM_AXES];     // serial in, msb first
    adc_word_u        held  [NUM_AXES];     // last complete frame

    assign cnt_nxt = (cnt == CNT_W'(ADC_FRAME - 1)) ? '0 : cnt + 1'b1;

    // ------------------------------
    // frame sequencer
    // ------------------------------
    // outputs are registered from the phase they will show
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            cnt          <= CNT_W'(ADC_FRAME - 1);  // first edge opens a frame
            adc_conv     <= 1'b0;
            adc_sclk     <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            cnt      <= cnt_nxt;
            adc_conv <= (cnt_nxt < CNT_W'(CONV_LEN));
            adc_sclk <= (cnt_nxt >= CNT_W'(SCLK_FIRST)) && (cnt_nxt <= CNT_W'(SCLK_LAST))
                        && !cnt_nxt[0];
            sample_valid <= adc_sclk && (cnt == CNT_W'(SCLK_LAST));  // after bit 32
        end
    end

    // miso sampled while sclk is high, device moves on the fall
    always_ff @(posedge sysclk) begin
        if (adc_sclk) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                shreg[i].raw <= {shreg[i].raw[2*SAMPLE_W-2:0], adc_miso[i]};
            end
        end
    end

    // held words move in with the last bit, same edge as sample_valid
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                held[i].raw <= {MID_SCALE, MID_SCALE};
            end
        end else if (adc_sclk && (cnt == CNT_W'(SCLK_LAST))) begin
            for (int i = 0; i < NUM_AXES; i++) begin
                held[i].raw <= {shreg[i].raw[2*SAMPLE_W-2:0], adc_miso[i]};
            end
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    always_comb begin
        adc_rdata = '0;
        for (int i = 0; i < NUM_AXES; i++) begin
            cur_fb[i] = held[i].f.cur;      // current half to safety check
            if (reg_addr[CHAN_LSB +: FIELD_W] == FIELD_W'(i + 1)) begin
                adc_rdata = {held[i].f.pot, held[i].f.cur};
            end
        end
    end

endmodule

//--- src/safety_monitor.sv
// per-axis over-current check; latches an amplifier disable until the host clears it
`timescale 1ns/10ps

module safety_monitor #(
    parameter int NUM_AXES      = 4,
    parameter int SAFETY_MARGIN = 64,
    parameter int SAFETY_COUNT  = 3
) (
    input  logic                                        sysclk,
    input  logic                                        rst_n,
    input  logic [NUM_AXES-1:0][qla_pkg::SAMPLE_W-1:0]  cur_cmd,
    input  logic [NUM_AXES-1:0][qla_pkg::SAMPLE_W-1:0]  cur_fb,
    input  logic                                        sample_valid,
    input  logic [NUM_AXES-1:0]                         clear_disable,
    output logic [NUM_AXES-1:0]                         amp_disable
);
    import qla_pkg::*;

    localparam int OC_W  = $clog2(SAFETY_COUNT + 1);
    localparam int CMP_W = SAMPLE_W + 2;    // room for 2x command + margin

    logic [SAMPLE_W-1:0] fb_mag  [NUM_AXES];
    logic [SAMPLE_W-1:0] cmd_mag [NUM_AXES];
    logic [CMP_W-1:0]    limit   [NUM_AXES];
    logic [NUM_AXES-1:0] over;              // this sample is over current
    logic [OC_W-1:0]     oc_cnt  [NUM_AXES];

    // distance from zero current, offset binary
    function automatic logic [SAMPLE_W-1:0] mag(input logic [SAMPLE_W-1:0] code);
        return (code >= MID_SCALE) ? code - MID_SCALE : MID_SCALE - code;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            fb_mag[i]  = mag(cur_fb[i]);
            cmd_mag[i] = mag(cur_cmd[i]);
            limit[i]   = {1'b0, cmd_mag[i], 1'b0} + CMP_W'(SAFETY_MARGIN);
            over[i]    = {2'b00, fb_mag[i]} > limit[i];
        end
    end

    // ------------------------------
    // persistence and latch
    // ------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_disable <= '0;
            for (int i = 0; i < NUM_AXES; i++) begin
                oc_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_AXES; i++) begin
                if (clear_disable[i]) begin         // host clear wins
                    amp_disable[i] <= 1'b0;
                    oc_cnt[i]      <= '0;
                end else if (sample_valid) begin
                    if (!over[i]) begin
                        oc_cnt[i] <= '0;            // streak broken
                    end else begin
                        if (oc_cnt[i] < OC_W'(SAFETY_COUNT)) begin
                            oc_cnt[i] <= oc_cnt[i] + 1'b1;  // saturates
                        end
                        if (oc_cnt[i] >= OC_W'(SAFETY_COUNT - 1)) begin
                            amp_disable[i] <= 1'b1; // trip on the Nth in a row
                        end
                    end
                end
            end
        end
    end

endmodule

//--- src/qla_motor_io.sv
// top level of the motor controller core; wishbone slave, current commands, adc and safety
`timescale 1ns/10ps

module qla_motor_io #(
    parameter int NUM_AXES      = 4,    // fits board register fields
    parameter int ADC_FRAME     = 80,   // cycles between conversions
    parameter int SAFETY_MARGIN = 64,   // codes above 2x command
    parameter int SAFETY_COUNT  = 3     // consecutive samples to trip
) (
    input  logic                       sysclk,
    input  logic                       rst_n,
    // wishbone classic slave
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [qla_pkg::ADDR_W-1:0] wb_adr,
    input  logic [qla_pkg::DATA_W-1:0] wb_dat_i,
    output logic [qla_pkg::DATA_W-1:0] wb_dat_o,
    output logic                       wb_ack,
    // serial adcs, shared conv/sclk
    output logic                       adc_conv,
    output logic                       adc_sclk,
    input  logic [NUM_AXES-1:0]        adc_miso,
    // amplifiers
    output logic [NUM_AXES-1:0]        amp_enable
);
    import qla_pkg::*;

    // ------------------------------
    // local wires
    // ------------------------------
    logic                               reg_wen;        // write strobe
    logic [ADDR_W-1:0]                  reg_addr;       // shared rd/wr address
    logic [DATA_W-1:0]                  reg_wdata;
    logic [DATA_W-1:0]                  cmd_rdata;      // command readback
    logic [DATA_W-1:0]                  adc_rdata;      // adc readback
    logic [NUM_AXES-1:0][SAMPLE_W-1:0]  cur_cmd;
    logic [NUM_AXES-1:0][SAMPLE_W-1:0]  cur_fb;
    logic                               sample_valid;   // once per frame
    logic [NUM_AXES-1:0]                amp_disable;    // latched trips
    logic [NUM_AXES-1:0]                clear_disable;  // from board reg writes

    // bus front end plus channel 0 board register
    wb_reg_slave #(.NUM_AXES(NUM_AXES)) u_slave (
        .sysclk(sysclk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .reg_wen(reg_wen), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .cmd_rdata(cmd_rdata), .adc_rdata(adc_rdata),
        .amp_disable(amp_disable), .clear_disable(clear_disable),
        .amp_enable(amp_enable)
    );

    dac_cmd_bank #(.NUM_AXES(NUM_AXES)) u_cmd (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .reg_addr(reg_addr), .reg_wdata(reg_wdata),
        .cur_cmd(cur_cmd), .cmd_rdata(cmd_rdata)
    );

    adc_sampler #(.NUM_AXES(NUM_AXES), .ADC_FRAME(ADC_FRAME)) u_adc (
        .sysclk(sysclk), .rst_n(rst_n),
        .adc_conv(adc_conv), .adc_sclk(adc_sclk), .adc_miso(adc_miso),
        .reg_addr(reg_addr), .adc_rdata(adc_rdata),
        .cur_fb(cur_fb), .sample_valid(sample_valid)
    );

    // compares feedback against 2x command per axis
    safety_monitor #(
        .NUM_AXES(NUM_AXES), .SAFETY_MARGIN(SAFETY_MARGIN), .SAFETY_COUNT(SAFETY_COUNT)
    ) u_safety (
        .sysclk(sysclk), .rst_n(rst_n),
        .cur_cmd(cur_cmd), .cur_fb(cur_fb), .sample_valid(sample_valid),
        .clear_disable(clear_disable), .amp_disable(amp_disable)
    );

endmodule

//--- tests/tb_qla_motor_io.sv
// testbench for qla_motor_io; drives wishbone accesses and a serial adc model, checks readback and trips
`timescale 1ns/10ps

module tb_qla_motor_io;
    import qla_pkg::*;

    localparam int NUM_AXES      = 4;
    localparam int ADC_FRAME     = 80;
    localparam int SAFETY_MARGIN = 64;
    localparam int SAFETY_COUNT  = 3;
    localparam int ACK_LIMIT     = 8;                       // cycles a bus access may take
    localparam int RUN_LIMIT     = 40 * ADC_FRAME + 200;    // whole run, in cycles

    logic                 sysclk = 1'b0;
    logic                 rst_n = 1'b0;
    logic                 wb_cyc = 1'b0;
    logic                 wb_stb = 1'b0;
    logic                 wb_we = 1'b0;
    logic [ADDR_W-1:0]    wb_adr = '0;
    logic [DATA_W-1:0]    wb_dat_i = '0;
    logic [DATA_W-1:0]    wb_dat_o;
    logic                 wb_ack;
    logic                 adc_conv;
    logic                 adc_sclk;
    logic [NUM_AXES-1:0]  adc_miso = '0;
    logic [NUM_AXES-1:0]  amp_enable;

    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycle_count = 0;
    logic [15:0] lfsr_state = 16'd61212;
    logic [31:0] serve_word [NUM_AXES];     // next frame's word per axis
    logic [31:0] shift_word [NUM_AXES];     // word being shifted out
    logic        conv_last = 1'b0;
    logic        sclk_last = 1'b0;
    int          sclk_pulses = 0;           // sclk rises since the last conv
    int          frames_started = 0;

    qla_motor_io #(
        .NUM_AXES(NUM_AXES), .ADC_FRAME(ADC_FRAME),
        .SAFETY_MARGIN(SAFETY_MARGIN), .SAFETY_COUNT(SAFETY_COUNT)
    ) dut0 (
        .sysclk(sysclk), .rst_n(rst_n),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .adc_conv(adc_conv), .adc_sclk(adc_sclk), .adc_miso(adc_miso),
        .amp_enable(amp_enable)
    );

    always #50 sysclk = ~sysclk;            // 100 ns period

    // ------------------------------
    // bus and safety properties
    // ------------------------------
    ack_next_cycle: assert property (@(posedge sysclk) disable iff (!rst_n)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else begin
            errors++;
            $display("slave did not acknowledge a request on the next cycle at %0t", $time);
        end
    ack_one_cycle: assert property (@(posedge sysclk) disable iff (!rst_n) wb_ack |=> !wb_ack)
        else begin
            errors++;
            $display("wb_ack stayed high for more than one cycle at %0t", $time);
        end
    amp_off_when_tripped: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(|(amp_enable & dut0.amp_disable)))
        else begin
            errors++;
            $display("amp_enable high on a disabled axis at %0t", $time);
        end

    // run limit
    always @(posedge sysclk) begin
        cycle_count++;
        if (cycle_count >= RUN_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // serial adc model
    // ------------------------------
    // reload on conv, next bit after each falling sclk
    always @(posedge sysclk) begin
        #5;
        for (int i = 0; i < NUM_AXES; i++) begin
            if (adc_conv && !conv_last) begin
                shift_word[i] = serve_word[i];
            end else if (!adc_sclk && sclk_last) begin
                shift_word[i] = shift_word[i] << 1;
            end
            adc_miso[i] = shift_word[i][31];        // msb first
        end
        // every complete frame carries exactly 32 serial clocks
        if (adc_conv && !conv_last) begin
            if (frames_started > 0) begin
                assert (sclk_pulses == 32)
                    else begin
                        errors++;
                        $display("Fail at %0t: adc_sclk pulses expected 32 got %0d",
                                 $time, sclk_pulses);
                    end
            end
            sclk_pulses = 0;
            frames_started++;
        end else if (adc_sclk && !sclk_last) begin
            sclk_pulses++;
        end
        conv_last = adc_conv;
        sclk_last = adc_sclk;
    end

    // 16 bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);     // one step per bit
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [ADDR_W-1:0] chan_addr(input int chan, input logic [3:0] off);
        return {BLK_MAIN, 4'h0, 4'(chan), off};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
            else begin
                errors++;
                $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
            end
    endtask

    // one classic cycle, ends 5 ns after the ack edge
    task automatic bus_access(input logic we, input logic [ADDR_W-1:0] adr,
                              input logic [DATA_W-1:0] wdat, output logic [DATA_W-1:0] rdat);
        int waited;
        waited = 0;
        @(posedge sysclk);
        #5;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_i = wdat;
        do begin
            @(posedge sysclk);
            #5;
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (!wb_ack) begin
            errors++;
            $display("no ack for address %h at %0t", adr, $time);
        end
        rdat = wb_dat_o;                    // valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] wdat);
        logic [DATA_W-1:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic read_expect(input string name, input logic [ADDR_W-1:0] adr,
                               input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] rdat;
        bus_access(1'b0, adr, '0, rdat);
        check_value(name, expected, rdat);
    endtask

    // counts rising edges of adc_conv, bounded
    task automatic wait_frames(input int n);
        int   seen;
        int   waited;
        logic prev;
        seen = 0;
        waited = 0;
        prev = adc_conv;
        while (seen < n && waited < n * ADC_FRAME + 20) begin
            @(posedge sysclk);
            #5;
            if (adc_conv && !prev) begin
                seen++;
            end
            prev = adc_conv;
            waited++;
        end
        if (seen < n) begin
            errors++;
            $display("adc_conv started only %0d of %0d frames", seen, n);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        logic [31:0] v;
        logic [31:0] cmd_words [NUM_AXES];
        logic [31:0] adc_words [NUM_AXES];
        int          e0;

        for (int i = 0; i < NUM_AXES; i++) begin
            serve_word[i] = {MID_SCALE, MID_SCALE};     // zero current until a test sets words
            shift_word[i] = {MID_SCALE, MID_SCALE};
        end

        // reset state, checked while rst_n is still low
        e0 = errors;
        repeat (2) @(posedge sysclk);
        #5;
        check_value("wb_ack", 32'(1'b0), 32'(wb_ack));
        check_value("adc_conv", 32'(1'b0), 32'(adc_conv));
        check_value("amp_enable", 32'(4'h0), 32'(amp_enable));
        rst_n = 1'b1;
        for (int i = 0; i < NUM_AXES; i++) begin
            read_expect("cmd after reset", chan_addr(i + 1, OFF_DAC_CTRL), 32'(MID_SCALE));
        end
        read_expect("board register", chan_addr(0, OFF_BOARD_STATUS), 32'h0);
        end_test("reset", e0);

        // command registers, random words, upper half must read zero
        e0 = errors;
        for (int i = 0; i < NUM_AXES; i++) begin
            random_bits(32, cmd_words[i]);
            bus_write(chan_addr(i + 1, OFF_DAC_CTRL), cmd_words[i]);
        end
        // writes outside the map leave every command alone
        bus_write(chan_addr(NUM_AXES + 1, OFF_DAC_CTRL), 32'h1234_5678);  // no such axis
        bus_write(16'h1011, 32'h8765_4321);                               // axis 0, other block
        for (int i = 0; i < NUM_AXES; i++) begin
            read_expect("cmd readback", chan_addr(i + 1, OFF_DAC_CTRL),
                        {16'h0, cmd_words[i][15:0]});
        end
        read_expect("unmapped channel", chan_addr(NUM_AXES + 1, OFF_DAC_CTRL), 32'h0);
        read_expect("unmapped block", 16'h1011, 32'h0);
        end_test("command registers", e0);

        // adc readback; cur kept below the margin so nothing trips here
        e0 = errors;
        for (int i = 0; i < NUM_AXES; i++) begin
            random_bits(16, v);
            adc_words[i][31:16] = v[15:0];
            random_bits(6, v);
            adc_words[i][15:0] = MID_SCALE + 16'(v[5:0]);
            serve_word[i] = adc_words[i];
        end
        wait_frames(3);                     // two whole frames with the new words
        for (int i = 0; i < NUM_AXES; i++) begin
            read_expect("adc word", chan_addr(i + 1, OFF_ADC_DATA), adc_words[i]);
        end
        end_test("adc readback", e0);

        // trip: limit is 2 * 100 + 64 = 264, axes 0..2 at 400, axis 3 at 200
        e0 = errors;
        bus_write(chan_addr(0, OFF_BOARD_STATUS), 32'h0000_000f);
        for (int i = 0; i < NUM_AXES; i++) begin
            bus_write(chan_addr(i + 1, OFF_DAC_CTRL), 32'(MID_SCALE + 16'd100));
            random_bits(16, v);
            serve_word[i] = {v[15:0], (i == NUM_AXES - 1) ? MID_SCALE + 16'd200
                                                          : MID_SCALE + 16'd400};
        end
        wait_frames(SAFETY_COUNT + 1);
        read_expect("board status", chan_addr(0, OFF_BOARD_STATUS), 32'h0000_070f);
        check_value("amp_enable", 32'(4'b1000), 32'(amp_enable));
        end_test("safety trip", e0);

        // back within limit, then a fresh enable write clears the latches
        e0 = errors;
        for (int i = 0; i < NUM_AXES; i++) begin
            serve_word[i][15:0] = MID_SCALE + 16'd100;
        end
        wait_frames(2);
        bus_write(chan_addr(0, OFF_BOARD_STATUS), 32'h0000_000f);
        check_value("amp_enable", 32'(4'hf), 32'(amp_enable));
        wait_frames(1);
        read_expect("board status", chan_addr(0, OFF_BOARD_STATUS), 32'h0000_000f);
        check_value("amp_enable", 32'(4'hf), 32'(amp_enable));
        end_test("clear and re-enable", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- qla_motor_io.f
src/qla_pkg.sv
src/wb_reg_slave.sv
src/dac_cmd_bank.sv
src/adc_sampler.sv
src/safety_monitor.sv
src/qla_motor_io.sv
tests/tb_qla_motor_io.sv

//--- Makefile
# Verilator build for the motor controller core and its testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_qla_motor_io
RTL_TOP    ?= qla_motor_io
FLIST      ?= qla_motor_io.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
